//--- flit_framer.sv
`timescale 1ns/1ns

module flit_framer (
    input  logic                              CLK,
    input  logic                              nRST,
    lane_sample_if.framer                     smp,
    output logic [link_frame_pkg::DATA_W-1:0] data,
    output link_frame_pkg::len_code_t         comma_sel,
    output logic                              done,
    output logic                              rx_err
);
    import link_frame_pkg::*;

    typedef enum logic [2:0] {
        S_HUNT,
        S_HEADER,
        S_DATA,
        S_STOP,
        S_RECOVER
    } frame_state_t;

    localparam int SLOT_W = $clog2(MAX_FLITS * FLIT_W / LANES);

    frame_state_t      state;
    len_code_t         len_q;
    len_code_t         hdr_code;
    logic [SLOT_W-1:0] slot;
    logic [SLOT_W-1:0] last_slot;
    logic [DATA_W-1:0] shift;
    logic              hdr_ok;

    // Number of data bit-times in a frame, less one.
    function automatic logic [SLOT_W-1:0] last_of(len_code_t code);
        logic [SLOT_W-1:0] n;
        case (code)
            LEN_1:   n = SLOT_W'(1 * FLIT_W / LANES - 1);
            LEN_2:   n = SLOT_W'(2 * FLIT_W / LANES - 1);
            LEN_5:   n = SLOT_W'(MAX_FLITS * FLIT_W / LANES - 1);
            default: n = '0;
        endcase
        return n;
    endfunction

    assign smp.hunt  = (state == S_HUNT);
    assign hdr_code  = len_code_t'(smp.bits[1:0]);
    assign hdr_ok    = (smp.bits[4:2] == HDR_MARK) && (hdr_code != LEN_NONE);
    assign last_slot = last_of(len_q);

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= S_HUNT;
            len_q     <= LEN_NONE;
            slot      <= '0;
            done      <= 1'b0;
            rx_err    <= 1'b0;
            data      <= '0;
            comma_sel <= LEN_NONE;
        end else begin
            done   <= 1'b0;
            rx_err <= 1'b0;
            case (state)
                S_HUNT: begin
                    // The sampler only strobes here once the start has been confirmed.
                    if (smp.strobe) begin
                        slot  <= '0;
                        state <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    if (smp.strobe) begin
                        if (hdr_ok) begin
                            len_q <= hdr_code;
                            state <= S_DATA;
                        end else begin
                            rx_err <= 1'b1;
                            state  <= S_RECOVER;
                        end
                    end
                end
                S_DATA: begin
                    if (smp.strobe) begin
                        slot <= slot + 1'b1;
                        if (slot == last_slot) begin
                            state <= S_STOP;
                        end
                    end
                end
                S_STOP: begin
                    if (smp.strobe) begin
                        if (&smp.bits) begin
                            data      <= shift;
                            comma_sel <= len_q;
                            done      <= 1'b1;
                            state     <= S_HUNT;
                        end else begin
                            rx_err <= 1'b1;
                            state  <= S_RECOVER;
                        end
                    end
                end
                S_RECOVER: begin
                    if (smp.idle) begin
                        state <= S_HUNT;
                    end
                end
                default: state <= S_HUNT;
            endcase
        end
    end

    // Flit assembly, five bits per data bit-time from bit 0 upward.
    always_ff @(posedge CLK) begin
        if (smp.strobe && (state == S_HUNT)) begin
            shift <= '0;
        end else if (smp.strobe && (state == S_DATA)) begin
            shift[slot*LANES +: LANES] <= smp.bits;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_start_is_low: assert property (
        @(posedge CLK) disable iff (!nRST)
        (smp.strobe && (state == S_HUNT)) |-> (smp.bits == '0)
    );

    a_done_has_len: assert property (
        @(posedge CLK) disable iff (!nRST)
        done |-> (comma_sel != LEN_NONE)
    );

endmodule

//--- lane_link_rx.sv
`timescale 1ns/1ns

module lane_link_rx (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [link_frame_pkg::LANES-1:0]  lanes,
    input  logic                              cfg_req,
    input  logic [link_cfg_pkg::DIV_W-1:0]    cfg_wdata,
    output logic                              cfg_ack,
    output logic [link_frame_pkg::DATA_W-1:0] data,
    output link_frame_pkg::len_code_t         comma_sel,
    output logic                              done,
    output logic                              rx_err
);
    import link_cfg_pkg::*;

    logic [DIV_W-1:0] bit_div;

    lane_sample_if smp_if ();

    link_cfg_regs i_link_cfg_regs (
        .CLK       (CLK),
        .nRST      (nRST),
        .cfg_req   (cfg_req),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .bit_div   (bit_div)
    );

    lane_sampler i_lane_sampler (
        .CLK     (CLK),
        .nRST    (nRST),
        .lanes   (lanes),
        .bit_div (bit_div),
        .smp     (smp_if.sampler)
    );

    flit_framer i_flit_framer (
        .CLK       (CLK),
        .nRST      (nRST),
        .smp       (smp_if.framer),
        .data      (data),
        .comma_sel (comma_sel),
        .done      (done),
        .rx_err    (rx_err)
    );

endmodule

//--- lane_sample_if.sv
`timescale 1ns/1ns

interface lane_sample_if;
    import link_frame_pkg::*;

    logic             strobe;
    logic [LANES-1:0] bits;
    logic             idle;
    logic             hunt;

    modport sampler (
        output strobe, bits, idle,
        input  hunt
    );

    modport framer (
        input  strobe, bits, idle,
        output hunt
    );

endinterface

//--- lane_sampler.sv
`timescale 1ns/1ns

module lane_sampler (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic [link_frame_pkg::LANES-1:0] lanes,
    input  logic [link_cfg_pkg::DIV_W-1:0]   bit_div,
    lane_sample_if.sampler                   smp
);
    import link_frame_pkg::*;
    import link_cfg_pkg::*;

    logic [LANES-1:0] sync_1;
    logic [LANES-1:0] sync_2;
    logic [DIV_W-1:0] div_q;
    logic [DIV_W-1:0] cnt;
    logic             active;
    logic             first;
    logic             hunt_q;
    logic             start_seen;
    logic             hunt_rise;
    logic             expire;
    logic             false_start;
    logic             fire;

    // ----------------------------------------
    // Lane synchronizer
    // ----------------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sync_1 <= '1;
            sync_2 <= '1;
        end else begin
            sync_1 <= lanes;
            sync_2 <= sync_1;
        end
    end

    assign smp.idle = &sync_2;

    // ----------------------------------------
    // Start search and bit timing
    // ----------------------------------------

    assign start_seen  = smp.hunt && !active && (sync_2 == '0);
    assign hunt_rise   = smp.hunt && !hunt_q;
    assign expire      = active && (cnt == '0);
    // The start bit must still be low at its middle, else it was a glitch.
    assign false_start = expire && first && (sync_2 != '0);
    assign fire        = expire && !false_start && !hunt_rise;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            first  <= 1'b0;
            hunt_q <= 1'b0;
            div_q  <= DIV_RESET;
            cnt    <= '0;
        end else begin
            hunt_q <= smp.hunt;
            if (start_seen) begin
                // Latch the period so a config write cannot disturb this frame.
                active <= 1'b1;
                first  <= 1'b1;
                div_q  <= bit_div;
                cnt    <= (bit_div >> 1) - 1'b1;
            end else if (hunt_rise || false_start) begin
                active <= 1'b0;
            end else if (expire) begin
                first <= 1'b0;
                cnt   <= div_q - 1'b1;
            end else if (active) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            smp.strobe <= 1'b0;
        end else begin
            smp.strobe <= fire;
        end
    end

    always_ff @(posedge CLK) begin
        if (fire) begin
            smp.bits <= sync_2;
        end
    end

endmodule

//--- link_cfg_pkg.sv
package link_cfg_pkg;

    // ----------------------------------------
    // Bit-period register
    // ----------------------------------------

    localparam int DIV_W = 10;

    // Bit period in CLK cycles after reset.
    localparam logic [DIV_W-1:0] DIV_RESET = 10'd16;

    // Anything shorter leaves no room for a mid-bit sample.
    localparam logic [DIV_W-1:0] DIV_MIN = 10'd4;

endpackage

//--- link_cfg_regs.sv
`timescale 1ns/1ns

module link_cfg_regs (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           cfg_req,
    input  logic [link_cfg_pkg::DIV_W-1:0] cfg_wdata,
    output logic                           cfg_ack,
    output logic [link_cfg_pkg::DIV_W-1:0] bit_div
);
    import link_cfg_pkg::*;

    logic take;

    // A new request is one that has not been acknowledged yet.
    assign take = cfg_req && !cfg_ack;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cfg_ack <= 1'b0;
        end else begin
            cfg_ack <= cfg_req;
        end
    end

    // Short periods are acknowledged like any other write but dropped.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            bit_div <= DIV_RESET;
        end else if (take && (cfg_wdata >= DIV_MIN)) begin
            bit_div <= cfg_wdata;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // The write data must not move while a request is up.
    a_wdata_held: assert property (
        @(posedge CLK) disable iff (!nRST)
        (cfg_req && $past(cfg_req)) |-> $stable(cfg_wdata)
    );

endmodule

//--- link_frame_pkg.sv
package link_frame_pkg;

    // ----------------------------------------
    // Frame format
    // ----------------------------------------

    localparam int LANES     = 5;
    localparam int FLIT_W    = 10;
    localparam int MAX_FLITS = 5;
    localparam int DATA_W    = FLIT_W * MAX_FLITS;

    // Value expected on header lanes 4..2.
    localparam logic [2:0] HDR_MARK = 3'b101;

    // Length code carried on header lanes 1..0.
    typedef enum logic [1:0] {
        LEN_NONE = 2'd0,
        LEN_1    = 2'd1,
        LEN_2    = 2'd2,
        LEN_5    = 2'd3
    } len_code_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_lane_link_rx -f sim.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/Vtb_lane_link_rx)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- sim.f
link_frame_pkg.sv
link_cfg_pkg.sv
lane_sample_if.sv
link_cfg_regs.sv
lane_sampler.sv
flit_framer.sv
lane_link_rx.sv
tb_clkgen.sv
tb_link_checker.sv
tb_lane_link_rx.sv

//--- tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
    output logic CLK,
    output logic nRST
);
    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Reset is held over three rising edges and let go on a falling edge.
    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

//--- tb_lane_link_rx.sv
`timescale 1ns/1ns

module tb_lane_link_rx;
    import link_frame_pkg::*;
    import link_cfg_pkg::*;

    localparam int ROWS     = 16;
    localparam int OUT_DONE = 0;
    localparam int OUT_ERR  = 1;
    localparam int OUT_NONE = 2;

    logic              CLK;
    logic              nRST;
    logic [LANES-1:0]  lanes;
    logic              cfg_req;
    logic [DIV_W-1:0]  cfg_wdata;
    logic              cfg_ack;
    logic [DATA_W-1:0] data;
    len_code_t         comma_sel;
    logic              done;
    logic              rx_err;
    logic              push;
    logic              flush;
    logic [8*16-1:0]   exp_name;
    logic              exp_err;
    len_code_t         exp_code;
    logic [DATA_W-1:0] exp_data;
    int                pending;
    int                checks;
    int                errors;
    int                own_errors;
    logic              table_loaded;

    // ----------------------------------------
    // Frame table
    // ----------------------------------------

    logic [8*16-1:0]  t_name     [ROWS];
    logic [DIV_W-1:0] t_wdiv     [ROWS];
    int               t_period   [ROWS];
    logic [1:0]       t_code     [ROWS];
    logic [2:0]       t_mark     [ROWS];
    int               t_flits    [ROWS];
    bit               t_rnd      [ROWS];
    bit               t_bad_stop [ROWS];
    bit               t_b2b      [ROWS];
    bit               t_glitch   [ROWS];
    int               t_out      [ROWS];
    int               n_rows;

    tb_clkgen i_clkgen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    lane_link_rx i_lane_link_rx (
        .CLK       (CLK),
        .nRST      (nRST),
        .lanes     (lanes),
        .cfg_req   (cfg_req),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .data      (data),
        .comma_sel (comma_sel),
        .done      (done),
        .rx_err    (rx_err)
    );

    tb_link_checker i_checker (
        .CLK       (CLK),
        .nRST      (nRST),
        .done      (done),
        .rx_err    (rx_err),
        .comma_sel (comma_sel),
        .data      (data),
        .push      (push),
        .flush     (flush),
        .exp_name  (exp_name),
        .exp_err   (exp_err),
        .exp_code  (exp_code),
        .exp_data  (exp_data),
        .pending   (pending),
        .checks    (checks),
        .errors    (errors)
    );

    task automatic add_row(input logic [8*16-1:0] name, input logic [DIV_W-1:0] wdiv,
                           input int period, input logic [1:0] code, input logic [2:0] mark,
                           input int flits, input bit rnd, input bit bad_stop, input bit b2b,
                           input bit glitch, input int out);
        t_name[n_rows]     = name;
        t_wdiv[n_rows]     = wdiv;
        t_period[n_rows]   = period;
        t_code[n_rows]     = code;
        t_mark[n_rows]     = mark;
        t_flits[n_rows]    = flits;
        t_rnd[n_rows]      = rnd;
        t_bad_stop[n_rows] = bad_stop;
        t_b2b[n_rows]      = b2b;
        t_glitch[n_rows]   = glitch;
        t_out[n_rows]      = out;
        n_rows++;
    endtask

    // A write value of zero means the row keeps the current bit period.
    task automatic load_table();
        add_row("one_flit", 10'd16, 16, 2'd1, HDR_MARK, 1, 1, 0, 0, 0, OUT_DONE);
        add_row("two_flits", 10'd0, 16, 2'd2, HDR_MARK, 2, 1, 0, 0, 0, OUT_DONE);
        add_row("five_flits", 10'd0, 16, 2'd3, HDR_MARK, 5, 1, 0, 0, 0, OUT_DONE);
        add_row("one_after_five", 10'd0, 16, 2'd1, HDR_MARK, 1, 0, 0, 0, 0, OUT_DONE);
        add_row("bad_code", 10'd0, 16, 2'd0, HDR_MARK, 0, 0, 0, 0, 0, OUT_ERR);
        add_row("bad_marker", 10'd0, 16, 2'd1, 3'b110, 0, 0, 0, 0, 0, OUT_ERR);
        add_row("after_bad", 10'd0, 16, 2'd2, HDR_MARK, 2, 1, 0, 0, 0, OUT_DONE);
        add_row("bad_stop", 10'd0, 16, 2'd1, HDR_MARK, 1, 1, 1, 0, 0, OUT_ERR);
        add_row("period_4", 10'd4, 4, 2'd3, HDR_MARK, 5, 1, 0, 0, 0, OUT_DONE);
        add_row("period_40", 10'd40, 40, 2'd2, HDR_MARK, 2, 1, 0, 0, 0, OUT_DONE);
        add_row("period_3_ignored", 10'd3, 40, 2'd1, HDR_MARK, 1, 1, 0, 0, 0, OUT_DONE);
        add_row("b2b_first", 10'd16, 16, 2'd2, HDR_MARK, 2, 1, 0, 1, 0, OUT_DONE);
        add_row("b2b_second", 10'd0, 16, 2'd3, HDR_MARK, 5, 1, 0, 1, 0, OUT_DONE);
        add_row("b2b_third", 10'd0, 16, 2'd1, HDR_MARK, 1, 1, 0, 0, 0, OUT_DONE);
        add_row("glitch", 10'd0, 16, 2'd0, HDR_MARK, 0, 0, 0, 0, 1, OUT_NONE);
        add_row("after_glitch", 10'd0, 16, 2'd1, HDR_MARK, 1, 1, 0, 0, 0, OUT_DONE);
    endtask

    task automatic send_bits(input logic [LANES-1:0] value, input int cycles);
        lanes = value;
        repeat (cycles) @(negedge CLK);
    endtask

    task automatic write_period(input logic [DIV_W-1:0] value);
        int i;
        cfg_wdata = value;
        cfg_req   = 1'b1;
        i = 0;
        while (!cfg_ack && i < 20) begin
            @(negedge CLK);
            i++;
        end
        if (!cfg_ack) begin
            $display("The bit period write of %0d was never acknowledged.", value);
            own_errors++;
        end
        cfg_req = 1'b0;
        i = 0;
        while (cfg_ack && i < 20) begin
            @(negedge CLK);
            i++;
        end
        if (cfg_ack) begin
            $display("The acknowledge stayed high after the write of %0d.", value);
            own_errors++;
        end
    endtask

    // Flit k fills bits 10k+9..10k, low half on the first of its two bit-times.
    task automatic send_frame(input int r, input logic [DATA_W-1:0] prev_data,
                              input len_code_t prev_code, output logic [DATA_W-1:0] word);
        logic [FLIT_W-1:0] flits [MAX_FLITS];
        int p;
        p    = t_period[r];
        word = '0;
        for (int k = 0; k < t_flits[r]; k++) begin
            flits[k] = t_rnd[r] ? FLIT_W'($urandom % 1024) : '1;
            word     = word | (DATA_W'(flits[k]) << (FLIT_W * k));
        end
        exp_name = t_name[r];
        exp_err  = (t_out[r] == OUT_ERR);
        exp_code = exp_err ? prev_code : len_code_t'(t_code[r]);
        exp_data = exp_err ? prev_data : word;
        lanes = '0;
        push  = 1'b1;
        @(negedge CLK);
        push = 1'b0;
        repeat (p - 1) @(negedge CLK);
        send_bits({t_mark[r], t_code[r]}, p);
        for (int k = 0; k < t_flits[r]; k++) begin
            send_bits(flits[k][4:0], p);
            send_bits(flits[k][9:5], p);
        end
        send_bits(t_bad_stop[r] ? 5'b11011 : 5'b11111, p);
        lanes = '1;
    endtask

    task automatic wait_result(input int limit);
        int i;
        i = 0;
        while (pending != 0 && i < limit) begin
            @(negedge CLK);
            i++;
        end
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] last_data;
        len_code_t         last_code;
        lanes        = '1;
        cfg_req      = 1'b0;
        cfg_wdata    = '0;
        push         = 1'b0;
        flush        = 1'b0;
        exp_name     = '0;
        exp_err      = 1'b0;
        exp_code     = LEN_NONE;
        exp_data     = '0;
        own_errors   = 0;
        n_rows       = 0;
        table_loaded = 1'b0;
        last_data    = '0;
        last_code    = LEN_NONE;
        void'($urandom(32'hafde_4e8a));
        load_table();
        table_loaded = 1'b1;
        @(posedge nRST);
        @(negedge CLK);
        for (int r = 0; r < n_rows; r++) begin
            if (t_wdiv[r] != '0) begin
                write_period(t_wdiv[r]);
            end
            if (t_glitch[r]) begin
                // Much shorter than half a bit, so the start is rejected.
                send_bits('0, 3);
                send_bits('1, 2 * t_period[r]);
                wait_result(4 * t_period[r]);
            end else begin
                send_frame(r, last_data, last_code, word);
                if (t_out[r] == OUT_DONE) begin
                    last_data = word;
                    last_code = len_code_t'(t_code[r]);
                end
                if (!t_b2b[r]) begin
                    send_bits('1, 2 * t_period[r]);
                    wait_result(4 * t_period[r]);
                end
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors + own_errors);
        if (errors + own_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Each row gets its bit-times at its own period plus room for the handshake.
    initial begin : watchdog
        int budget;
        wait (table_loaded);
        budget = 200;
        for (int r = 0; r < n_rows; r++) begin
            budget += (9 + 2 * t_flits[r]) * t_period[r] + 60;
        end
        #(budget * 20);
        $display("The watchdog expired before all frames were checked.");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb_link_checker.sv
`timescale 1ns/1ns

module tb_link_checker (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              done,
    input  logic                              rx_err,
    input  link_frame_pkg::len_code_t         comma_sel,
    input  logic [link_frame_pkg::DATA_W-1:0] data,
    input  logic                              push,
    input  logic                              flush,
    input  logic [8*16-1:0]                   exp_name,
    input  logic                              exp_err,
    input  link_frame_pkg::len_code_t         exp_code,
    input  logic [link_frame_pkg::DATA_W-1:0] exp_data,
    output int                                pending,
    output int                                checks,
    output int                                errors
);
    import link_frame_pkg::*;

    // Expected results in frame order.
    logic [8*16-1:0]   q_name [$];
    logic              q_err  [$];
    len_code_t         q_code [$];
    logic [DATA_W-1:0] q_data [$];

    always @(posedge CLK) begin : watch
        logic [8*16-1:0]   name;
        logic              e;
        len_code_t         c;
        logic [DATA_W-1:0] d;
        if (!nRST) begin
            checks  = 0;
            errors  = 0;
            pending = 0;
        end else begin
            if (done || rx_err) begin
                if (q_name.size() == 0) begin
                    $display("A result pulse arrived at %0t with no frame pending.", $time);
                    errors++;
                end else begin
                    name = q_name.pop_front();
                    e    = q_err.pop_front();
                    c    = q_code.pop_front();
                    d    = q_data.pop_front();
                    checks += 3;
                    if (done == e || rx_err != e) begin
                        $display("FAILED %0s: result expected %s, actual %s", name,
                                 e ? "rx_err" : "done", done ? "done" : "rx_err");
                        errors++;
                    end
                    if (comma_sel !== c) begin
                        $display("FAILED %0s: comma_sel expected %0d, actual %0d",
                                 name, c, comma_sel);
                        errors++;
                    end
                    if (data !== d) begin
                        $display("FAILED %0s: data expected %h, actual %h", name, d, data);
                        errors++;
                    end
                end
            end
            if (push) begin
                q_name.push_back(exp_name);
                q_err.push_back(exp_err);
                q_code.push_back(exp_code);
                q_data.push_back(exp_data);
            end
            if (flush) begin
                while (q_name.size() > 0) begin
                    $display("No result pulse arrived for test %0s.", q_name.pop_front());
                    void'(q_err.pop_front());
                    void'(q_code.pop_front());
                    void'(q_data.pop_front());
                    errors++;
                end
            end
            pending = q_name.size();
        end
    end

endmodule
